/* list.f */
+incdir+tb
common/pw_pkg.sv
trigger/pattern_matcher.sv
trigger/trigger_pulse_gen.sv
capture/rx_event_encoder.sv
capture/capture_fifo.sv
capture/capture_ctrl.sv
logic/usb_capture_top.sv
tb/tb_usb_capture.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the USB capture testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_usb_capture -f list.f -o tb_usb_capture > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/tb_usb_capture > sim.log 2>&1
if [ $? -ne 0 ]; then
   echo "simulation ended with an error, see sim.log"
   exit 1
fi

if grep -qF "*** PASSED ***" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

/* tb/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference model stepped once per rising edge
//////////////////////////////////////////////////////////////////////

typedef enum int {
   M_WAIT,
   M_RUN,
   M_DONE
} mcap_e;

int                   m_edge = 0;              // rising edges seen
logic                 m_act;                   // rxactive at previous edge
logic                 m_err;                   // rxerror seen in this packet
logic                 m_armed;
logic                 m_match;                 // registered match
logic [7:0]           m_win [PATTERN_BYTES];   // lane 0 newest
int                   m_fill;
mcap_e                m_cap;
int                   m_rec_cnt;
int                   m_ref_edge;              // last record or capture start
logic                 m_enc_valid;
logic [REC_WIDTH-1:0] m_enc_rec;
logic [REC_WIDTH-1:0] m_fifo [$];              // expected output stream
logic                 m_ovf;
int                   m_trg_on;                // first edge with trigger high
int                   m_trg_off;               // first edge low again

function automatic logic last_rec_due();
   return (m_cap == M_RUN) && m_enc_valid && (m_rec_cnt + 1 == int'(capture_len));
endfunction

function automatic logic capturing_expected();
   return (m_cap == M_RUN) && !last_rec_due();
endfunction

function automatic logic done_expected();
   return (m_cap == M_DONE) || last_rec_due();
endfunction

function automatic logic trigger_expected();
   return (m_edge >= m_trg_on) && (m_edge < m_trg_off);
endfunction

// masked compare over the programmed number of bytes
function automatic logic window_matches();
   for (int b = 0; b < int'(pattern_bytes); b++) begin
      if (((m_win[b] ^ pattern[b*8 +: 8]) & mask[b*8 +: 8]) != 8'h00) begin
         return 1'b0;
      end
   end
   return 1'b1;
endfunction

task automatic reset_model();
   m_act       = 1'b0;
   m_err       = 1'b0;
   m_armed     = 1'b0;
   m_match     = 1'b0;
   m_fill      = 0;
   m_cap       = M_WAIT;
   m_rec_cnt   = 0;
   m_ref_edge  = 0;
   m_enc_valid = 1'b0;
   m_enc_rec   = '0;
   m_ovf       = 1'b0;
   m_trg_on    = 0;
   m_trg_off   = 0;
   m_fifo.delete();
endtask

task automatic step_model();
   logic       take;
   logic       start_ev;
   logic       end_ev;
   logic       last;
   logic       emit;
   logic       full;
   logic       hit;
   logic [7:0] rec_byte;
   rec_cmd_e   cmd;
   int         t;
   m_edge++;
   take     = fe_rxactive & fe_rxvalid;
   start_ev = fe_rxactive & ~m_act;
   end_ev   = ~fe_rxactive & m_act;
   last     = last_rec_due();
   emit     = capturing_expected() & (start_ev | take | end_ev);
   hit      = 1'b0;

   // fifo fullness is judged before this edge's pop
   full = (m_fifo.size() == FIFO_DEPTH);
   if (rec_ready && m_fifo.size() != 0) begin
      void'(m_fifo.pop_front());
   end
   if (m_enc_valid && !full) begin
      m_fifo.push_back(m_enc_rec);
   end
   m_ovf = (m_ovf & ~arm) | (m_enc_valid & full);

   // capture window
   if (arm) begin
      m_cap     = M_WAIT;
      m_rec_cnt = 0;
   end else if (m_cap == M_WAIT && m_match) begin
      m_cap      = M_RUN;
      m_ref_edge = m_edge;                    // time base for first record
   end else if (m_cap == M_RUN) begin
      if (m_enc_valid) begin
         m_rec_cnt++;
      end
      if (last) begin
         m_cap = M_DONE;
      end
   end

   // encoder gives start priority over a byte
   if (emit) begin
      t = m_edge - m_ref_edge;
      if (t > 255) begin
         t = 255;                             // saturating timestamp
      end
      if (start_ev) begin
         cmd      = REC_START;
         rec_byte = 8'h00;
      end else if (end_ev) begin
         cmd      = REC_END;
         rec_byte = {7'b0, m_err};
      end else begin
         cmd      = REC_DATA;
         rec_byte = fe_data;
      end
      m_enc_rec  = {cmd, 8'(t), rec_byte};
      m_ref_edge = m_edge;
   end
   m_enc_valid = emit;
   if (end_ev) begin
      m_err = 1'b0;
   end else if (fe_rxactive && fe_rxerror) begin
      m_err = 1'b1;
   end

   // trigger ignores matches until the pulse is over
   if (m_match && m_edge > m_trg_off) begin
      m_trg_on  = m_edge + int'(trig_delay) + 1;
      m_trg_off = m_trg_on + ((trig_width == '0) ? 1 : int'(trig_width));
   end

   // matcher
   if (!fe_rxactive) begin
      m_fill = 0;
   end else if (take) begin
      for (int b = PATTERN_BYTES - 1; b > 0; b--) begin
         m_win[b] = m_win[b-1];
      end
      m_win[0] = fe_data;
      if (m_fill < PATTERN_BYTES) begin
         m_fill++;
      end
      hit = m_armed && (m_fill >= int'(pattern_bytes)) && window_matches();
   end
   m_match = hit;
   if (arm) begin
      m_armed = 1'b1;
   end else if (hit) begin
      m_armed = 1'b0;
   end
   m_act = fe_rxactive;
endtask

`endif

/* tb/tb_usb_capture.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_usb_capture import pw_pkg::*; ();

   localparam int ROUNDS         = 6;
   localparam int PACKETS        = 40;
   localparam int TIMEOUT_CYCLES = ROUNDS * (PACKETS * 30 + 4096) + 1000;

   logic                         fe_clk = 1'b0;
   logic                         arst_n;
   logic [7:0]                   fe_data;
   logic                         fe_rxvalid;
   logic                         fe_rxactive;
   logic                         fe_rxerror;
   logic                         arm;
   logic [PATTERN_WIDTH-1:0]     pattern;
   logic [PATTERN_WIDTH-1:0]     mask;
   logic [PATTERN_CNT_WIDTH-1:0] pattern_bytes;
   logic [CAPTURE_LEN_WIDTH-1:0] capture_len;
   logic [TRIG_DELAY_WIDTH-1:0]  trig_delay;
   logic [TRIG_WIDTH_WIDTH-1:0]  trig_width;
   logic [REC_WIDTH-1:0]         rec_data;
   logic                         rec_valid;
   logic                         rec_ready;
   logic                         capturing;
   logic                         capture_done;
   logic                         overflow;
   logic                         cw_trig;

   integer seed;
   int     cycle_cnt    = 0;
   int     mismatch_cnt = 0;
   int     lost_cnt     = 0;
   int     extra_cnt    = 0;
   int     stall_left   = 0;
   logic   drain        = 1'b0;   // consumer always ready

   usb_capture_top usb_capture_top_i (
      .fe_clk_i        (fe_clk),
      .arst_n_i        (arst_n),
      .fe_data_i       (fe_data),
      .fe_rxvalid_i    (fe_rxvalid),
      .fe_rxactive_i   (fe_rxactive),
      .fe_rxerror_i    (fe_rxerror),
      .arm_i           (arm),
      .pattern_i       (pattern),
      .mask_i          (mask),
      .pattern_bytes_i (pattern_bytes),
      .capture_len_i   (capture_len),
      .trig_delay_i    (trig_delay),
      .trig_width_i    (trig_width),
      .rec_data_o      (rec_data),
      .rec_valid_o     (rec_valid),
      .rec_ready_i     (rec_ready),
      .capturing_o     (capturing),
      .capture_done_o  (capture_done),
      .overflow_o      (overflow),
      .cw_trig_o       (cw_trig)
   );

   `include "tb_model.svh"

   always #4 fe_clk = ~fe_clk;   // 8 ns period

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // advance one cycle and drive inputs 1 ns after the edge
   task automatic tick();
      @(posedge fe_clk);
      #1;
      if (drain) begin
         rec_ready = 1'b1;
      end else if (stall_left > 0) begin
         rec_ready = 1'b0;
         stall_left--;
      end else if (rand_below(64) == 0) begin
         rec_ready  = 1'b0;
         stall_left = 30 + rand_below(32);   // long back-pressure stretch
      end else begin
         rec_ready = (rand_below(2) != 0);
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] exp_val,
                            input logic [31:0] got_val);
      assert (exp_val === got_val) else begin
         mismatch_cnt++;
         $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp_val, got_val);
      end
   endtask

   task automatic arm_pulse();
      arm = 1'b1;
      tick();
      arm = 1'b0;
   endtask

   // pattern lanes lane_lo up to lane_hi-1 go into the packet
   task automatic send_packet(input int lane_lo, input int lane_hi);
      logic [7:0] pkt [12];
      int         len;
      int         n_emb;
      int         last;
      int         err_at;
      int         gap;
      len   = 1 + rand_below(12);
      n_emb = lane_hi - lane_lo;
      if (len < n_emb) begin
         len = n_emb;
      end
      for (int i = 0; i < len; i++) begin
         pkt[i] = 8'(rand_below(256));
      end
      if (n_emb > 0) begin
         if (lane_lo > 0) begin
            last = len - 1;                   // older part of a split pattern ends it
         end else if (lane_hi < int'(pattern_bytes)) begin
            last = n_emb - 1;                 // younger part of a split pattern opens it
         end else begin
            last = n_emb - 1 + rand_below(len - n_emb + 1);
         end
         // the lowest lane arrives last
         // masked-off bits keep their random value
         for (int k = lane_lo; k < lane_hi; k++) begin
            pkt[last-k+lane_lo] = (pattern[k*8 +: 8] & mask[k*8 +: 8])
                                | (pkt[last-k+lane_lo] & ~mask[k*8 +: 8]);
         end
      end
      err_at = (rand_below(8) == 0) ? rand_below(len) : -1;
      fe_rxactive = 1'b1;                     // rxactive leads the first byte
      tick();
      for (int i = 0; i < len; i++) begin
         if (rand_below(4) == 0) begin
            fe_rxvalid = 1'b0;
            fe_rxerror = 1'b0;
            tick();
         end
         fe_rxvalid = 1'b1;
         fe_data    = pkt[i];
         fe_rxerror = (i == err_at);
         tick();
      end
      fe_rxvalid  = 1'b0;
      fe_rxerror  = 1'b0;
      fe_rxactive = 1'b0;
      fe_data     = 8'h00;
      gap = (rand_below(16) == 0) ? 260 + rand_below(40) : 1 + rand_below(6);
      repeat (gap) tick();
   endtask

   //////////////////////////////////////////////////////////////////////
   // model stepping, timeout and output checks
   //////////////////////////////////////////////////////////////////////

   always @(posedge fe_clk) begin
      cycle_cnt++;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("*** FAILED ***");
         $finish;
      end else if (!arst_n) begin
         reset_model();
      end else begin
         step_model();
      end
   end

   always @(negedge fe_clk) begin
      if (arst_n) begin
         check_val("capturing_o", capturing_expected(), capturing);
         check_val("capture_done_o", done_expected(), capture_done);
         check_val("overflow_o", m_ovf, overflow);
         check_val("cw_trig_o", trigger_expected(), cw_trig);
         assert (rec_valid || m_fifo.size() == 0) else begin
            lost_cnt++;
            $display("record lost at %0t ns: expected %h was not presented", $time, m_fifo[0]);
         end
         assert (!rec_valid || m_fifo.size() != 0) else begin
            extra_cnt++;
            $display("extra record at %0t ns: %h was not expected", $time, rec_data);
         end
         if (rec_valid && m_fifo.size() != 0) begin
            check_val("rec_data_o", m_fifo[0], rec_data);
         end
      end
   end

   initial begin
      int kind;
      int nb;
      int cut;
      seed          = 99737;
      arst_n        = 1'b0;
      fe_data       = 8'h00;
      fe_rxvalid    = 1'b0;
      fe_rxactive   = 1'b0;
      fe_rxerror    = 1'b0;
      arm           = 1'b0;
      pattern       = '0;
      mask          = '0;
      pattern_bytes = PATTERN_CNT_WIDTH'(1);
      capture_len   = CAPTURE_LEN_WIDTH'(1);
      trig_delay    = '0;
      trig_width    = '0;
      rec_ready     = 1'b0;
      tick();
      tick();
      arst_n = 1'b1;

      for (int r = 0; r < ROUNDS; r++) begin
         pattern       = {$random(seed), $random(seed)};
         mask          = {$random(seed), $random(seed)} | {$random(seed), $random(seed)};
         pattern_bytes = PATTERN_CNT_WIDTH'(1 + rand_below(PATTERN_BYTES));
         capture_len   = CAPTURE_LEN_WIDTH'(1 + rand_below(40));
         trig_delay    = TRIG_DELAY_WIDTH'(rand_below(2048));
         // round 0 runs with width 0, which gives a one cycle pulse
         trig_width    = (r == 0) ? '0 : TRIG_WIDTH_WIDTH'(rand_below(256));
         arm_pulse();
         for (int p = 0; p < PACKETS; p++) begin
            if (p == PACKETS / 2) begin
               arm_pulse();                   // re-arm may land in a busy trigger
            end
            kind = rand_below(8);
            nb   = int'(pattern_bytes);
            if (kind < 2) begin
               send_packet(0, nb);
            end else if (kind == 2 && nb > 1) begin
               cut = 1 + rand_below(nb - 1);  // pattern split over two packets
               send_packet(cut, nb);
               send_packet(0, cut);
            end else begin
               send_packet(0, 0);
            end
         end
         // empty the stream and let the trigger finish before new settings
         drain = 1'b1;
         while (m_fifo.size() != 0 || m_enc_valid || rec_valid || m_edge < m_trg_off) begin
            tick();
         end
         drain = 1'b0;
      end

      $display("errors: %0d mismatches, %0d lost records, %0d extra records",
               mismatch_cnt, lost_cnt, extra_cnt);
      if (mismatch_cnt + lost_cnt + extra_cnt == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* logic/usb_capture_top.sv */
`default_nettype none
`timescale 1ns/10ps

module usb_capture_top import pw_pkg::*; (
   input  wire                         fe_clk_i,
   input  wire                         arst_n_i,

   // front end PHY receive side
   input  wire [7:0]                   fe_data_i,
   input  wire                         fe_rxvalid_i,
   input  wire                         fe_rxactive_i,
   input  wire                         fe_rxerror_i,

   // configuration, stable while armed
   input  wire                         arm_i,
   input  wire [PATTERN_WIDTH-1:0]     pattern_i,
   input  wire [PATTERN_WIDTH-1:0]     mask_i,
   input  wire [PATTERN_CNT_WIDTH-1:0] pattern_bytes_i,
   input  wire [CAPTURE_LEN_WIDTH-1:0] capture_len_i,
   input  wire [TRIG_DELAY_WIDTH-1:0]  trig_delay_i,
   input  wire [TRIG_WIDTH_WIDTH-1:0]  trig_width_i,

   // record stream
   output logic [REC_WIDTH-1:0]        rec_data_o,
   output logic                        rec_valid_o,
   input  wire                         rec_ready_i,

   // status
   output logic                        capturing_o,
   output logic                        capture_done_o,
   output logic                        overflow_o,
   output logic                        cw_trig_o
);

   logic                 match;
   logic [REC_WIDTH-1:0] enc_rec;
   logic                 enc_rec_valid;

   //////////////////////////////////////////////////////////////////////
   // match and trigger
   //////////////////////////////////////////////////////////////////////

   pattern_matcher pattern_matcher_i (
      .fe_clk_i        (fe_clk_i),
      .arst_n_i        (arst_n_i),
      .arm_i           (arm_i),
      .rx_active_i     (fe_rxactive_i),
      .rx_valid_i      (fe_rxvalid_i),
      .rx_data_i       (fe_data_i),
      .pattern_i       (pattern_i),
      .mask_i          (mask_i),
      .pattern_bytes_i (pattern_bytes_i),
      .match_o         (match)
   );

   trigger_pulse_gen trigger_pulse_gen_i (
      .fe_clk_i        (fe_clk_i),
      .arst_n_i        (arst_n_i),
      .match_i         (match),
      .trig_delay_i    (trig_delay_i),
      .trig_width_i    (trig_width_i),
      .trig_o          (cw_trig_o)
   );

   //////////////////////////////////////////////////////////////////////
   // capture path
   //////////////////////////////////////////////////////////////////////

   capture_ctrl capture_ctrl_i (
      .fe_clk_i        (fe_clk_i),
      .arst_n_i        (arst_n_i),
      .arm_i           (arm_i),
      .match_i         (match),
      .rec_valid_i     (enc_rec_valid),
      .capture_len_i   (capture_len_i),
      .capturing_o     (capturing_o),
      .capture_done_o  (capture_done_o)
   );

   rx_event_encoder rx_event_encoder_i (
      .fe_clk_i        (fe_clk_i),
      .arst_n_i        (arst_n_i),
      .capturing_i     (capturing_o),
      .rx_active_i     (fe_rxactive_i),
      .rx_valid_i      (fe_rxvalid_i),
      .rx_error_i      (fe_rxerror_i),
      .rx_data_i       (fe_data_i),
      .rec_o           (enc_rec),
      .rec_valid_o     (enc_rec_valid)
   );

   capture_fifo capture_fifo_i (
      .fe_clk_i        (fe_clk_i),
      .arst_n_i        (arst_n_i),
      .clear_i         (arm_i),          // arm clears overflow
      .wr_i            (enc_rec_valid),
      .wr_data_i       (enc_rec),
      .rd_data_o       (rec_data_o),
      .rd_valid_o      (rec_valid_o),
      .rd_ready_i      (rec_ready_i),
      .overflow_o      (overflow_o)
   );

endmodule

`default_nettype wire

/* capture/capture_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module capture_ctrl import pw_pkg::*; (
   input  wire                         fe_clk_i,
   input  wire                         arst_n_i,
   input  wire                         arm_i,
   input  wire                         match_i,
   input  wire                         rec_valid_i,
   input  wire [CAPTURE_LEN_WIDTH-1:0] capture_len_i,
   output logic                        capturing_o,
   output logic                        capture_done_o
);

   typedef enum logic [1:0] {
      CAP_WAIT,
      CAP_RUN,
      CAP_DONE
   } cap_state_e;

   cap_state_e                   state_q;
   logic [CAPTURE_LEN_WIDTH-1:0] rec_cnt_q;
   logic [CAPTURE_LEN_WIDTH-1:0] rec_cnt_next;
   logic                         last_rec;

   assign rec_cnt_next = rec_cnt_q + 1'b1;

   // the record that reaches the length closes the window right away,
   // so the encoder cannot slip in one more on the following edge
   assign last_rec = (state_q == CAP_RUN) & rec_valid_i & (rec_cnt_next == capture_len_i);

   assign capturing_o    = (state_q == CAP_RUN) & ~last_rec;
   assign capture_done_o = (state_q == CAP_DONE) | last_rec;

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= CAP_WAIT;
         rec_cnt_q <= '0;
      end else if (arm_i) begin
         state_q   <= CAP_WAIT;           // re-arm clears done and count
         rec_cnt_q <= '0;
      end else begin
         case (state_q)
            CAP_WAIT: begin
               if (match_i) begin
                  state_q <= CAP_RUN;
               end
            end
            CAP_RUN: begin
               if (rec_valid_i) begin
                  rec_cnt_q <= rec_cnt_next;  // length 0 runs until wrap
               end
               if (last_rec) begin
                  state_q <= CAP_DONE;
               end
            end
            CAP_DONE: begin
               state_q <= CAP_DONE;       // held until next arm
            end
            default: begin
               state_q <= CAP_WAIT;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* capture/capture_fifo.sv */
`default_nettype none
`timescale 1ns/10ps

module capture_fifo import pw_pkg::*; (
   input  wire                  fe_clk_i,
   input  wire                  arst_n_i,
   input  wire                  clear_i,
   input  wire                  wr_i,
   input  wire [REC_WIDTH-1:0]  wr_data_i,
   output logic [REC_WIDTH-1:0] rd_data_o,
   output logic                 rd_valid_o,
   input  wire                  rd_ready_i,
   output logic                 overflow_o
);

   logic [REC_WIDTH-1:0]     mem [FIFO_DEPTH];
   logic [FIFO_ADDR_WIDTH-1:0] wr_ptr_q;
   logic [FIFO_ADDR_WIDTH-1:0] rd_ptr_q;
   logic [FIFO_ADDR_WIDTH:0]   count_q;
   logic                       full;
   logic                       push;
   logic                       pop;
   logic                       drop;

   // a pop in the same cycle does not free a slot for the write
   assign full = (count_q == (FIFO_ADDR_WIDTH+1)'(FIFO_DEPTH));
   assign push = wr_i & ~full;
   assign drop = wr_i & full;
   assign pop  = rd_ready_i & rd_valid_o;

   // first word fall through
   assign rd_valid_o = (count_q != '0);
   assign rd_data_o  = mem[rd_ptr_q];

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         overflow_o <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         count_q    <= count_q + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
         overflow_o <= (overflow_o & ~clear_i) | drop;  // sticky until arm
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (push) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

endmodule

`default_nettype wire

/* capture/rx_event_encoder.sv */
`default_nettype none
`timescale 1ns/10ps

module rx_event_encoder import pw_pkg::*; (
   input  wire                  fe_clk_i,
   input  wire                  arst_n_i,
   input  wire                  capturing_i,
   input  wire                  rx_active_i,
   input  wire                  rx_valid_i,
   input  wire                  rx_error_i,
   input  wire [7:0]            rx_data_i,
   output logic [REC_WIDTH-1:0] rec_o,
   output logic                 rec_valid_o
);

   logic                  act_q;
   logic                  cap_q;
   logic                  err_q;
   logic                  start_ev;
   logic                  data_ev;
   logic                  end_ev;
   logic                  cap_rise;
   logic                  emit;
   logic [TIME_WIDTH-1:0] ts_q;
   logic [TIME_WIDTH-1:0] ts_now;
   rec_cmd_e              cmd;
   logic [7:0]            rec_byte;

   //////////////////////////////////////////////////////////////////////
   // event detect
   //////////////////////////////////////////////////////////////////////

   assign start_ev = rx_active_i & ~act_q;
   assign end_ev   = ~rx_active_i & act_q;
   assign data_ev  = rx_active_i & rx_valid_i;
   assign cap_rise = capturing_i & ~cap_q;
   assign emit     = capturing_i & (start_ev | data_ev | end_ev);

   // first edge of a capture counts as 1 since capturing rose
   assign ts_now = cap_rise ? TIME_WIDTH'(1) : ts_q;

   // one record per edge; start wins over a byte on the same edge
   always_comb begin
      if (start_ev) begin
         cmd      = REC_START;
         rec_byte = 8'h00;
      end else if (end_ev) begin
         cmd      = REC_END;
         rec_byte = {7'b0, err_q};
      end else begin
         cmd      = REC_DATA;
         rec_byte = rx_data_i;
      end
   end

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         act_q       <= 1'b0;
         cap_q       <= 1'b0;
         err_q       <= 1'b0;
         ts_q        <= '0;
         rec_valid_o <= 1'b0;
      end else begin
         act_q       <= rx_active_i;
         cap_q       <= capturing_i;
         rec_valid_o <= emit;
         if (end_ev) begin
            err_q <= 1'b0;                          // per packet
         end else if (rx_active_i && rx_error_i) begin
            err_q <= 1'b1;
         end
         if (emit) begin
            ts_q <= TIME_WIDTH'(1);
         end else if (ts_now != '1) begin
            ts_q <= ts_now + 1'b1;                  // saturates at 255
         end else begin
            ts_q <= ts_now;
         end
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (emit) begin
         rec_o <= {cmd, ts_now, rec_byte};
      end
   end

endmodule

`default_nettype wire

/* trigger/trigger_pulse_gen.sv */
`default_nettype none
`timescale 1ns/10ps

module trigger_pulse_gen import pw_pkg::*; (
   input  wire                        fe_clk_i,
   input  wire                        arst_n_i,
   input  wire                        match_i,
   input  wire [TRIG_DELAY_WIDTH-1:0] trig_delay_i,
   input  wire [TRIG_WIDTH_WIDTH-1:0] trig_width_i,
   output logic                       trig_o
);

   typedef enum logic [1:0] {
      TRG_IDLE,
      TRG_DELAY,
      TRG_PULSE
   } trg_state_e;

   trg_state_e                  state_q;
   logic [TRIG_DELAY_WIDTH-1:0] cnt_q;     // delay is the wider of the two
   logic [TRIG_DELAY_WIDTH-1:0] width_m1;

   // width 0 behaves as 1
   assign width_m1 = (trig_width_i == '0) ? '0
                                          : TRIG_DELAY_WIDTH'(trig_width_i - 1'b1);

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= TRG_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            TRG_IDLE: begin
               if (match_i) begin        // matches while busy are dropped
                  state_q <= TRG_DELAY;
                  cnt_q   <= trig_delay_i;
               end
            end
            TRG_DELAY: begin
               if (cnt_q == '0) begin
                  state_q <= TRG_PULSE;
                  cnt_q   <= width_m1;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            TRG_PULSE: begin
               if (cnt_q == '0) begin
                  state_q <= TRG_IDLE;
               end else begin
                  cnt_q <= cnt_q - 1'b1;
               end
            end
            default: begin
               state_q <= TRG_IDLE;
            end
         endcase
      end
   end

   assign trig_o = (state_q == TRG_PULSE);  // straight from state reg

endmodule

`default_nettype wire

/* trigger/pattern_matcher.sv */
`default_nettype none
`timescale 1ns/10ps

module pattern_matcher import pw_pkg::*; (
   input  wire                         fe_clk_i,
   input  wire                         arst_n_i,
   input  wire                         arm_i,
   input  wire                         rx_active_i,
   input  wire                         rx_valid_i,
   input  wire [7:0]                   rx_data_i,
   input  wire [PATTERN_WIDTH-1:0]     pattern_i,
   input  wire [PATTERN_WIDTH-1:0]     mask_i,
   input  wire [PATTERN_CNT_WIDTH-1:0] pattern_bytes_i,
   output logic                        match_o
);

   logic [PATTERN_WIDTH-1:0]     window_q;
   logic [PATTERN_WIDTH-1:0]     window_next;
   logic [PATTERN_WIDTH-1:0]     byte_en;
   logic [PATTERN_CNT_WIDTH-1:0] fill_q;
   logic [PATTERN_CNT_WIDTH-1:0] fill_next;
   logic                         armed_q;
   logic                         take;
   logic                         hit;

   assign take        = rx_active_i & rx_valid_i;
   assign window_next = {window_q[PATTERN_WIDTH-9:0], rx_data_i};  // newest byte in lane 0
   assign fill_next   = (fill_q == PATTERN_CNT_WIDTH'(PATTERN_BYTES)) ? fill_q
                                                                       : fill_q + 1'b1;

   // only the lowest pattern_bytes_i lanes take part
   always_comb begin
      for (int b = 0; b < PATTERN_BYTES; b++) begin
         byte_en[b*8 +: 8] = (b < pattern_bytes_i) ? 8'hff : 8'h00;
      end
   end

   assign hit = take & armed_q & (fill_next >= pattern_bytes_i)
              & ~|((window_next ^ pattern_i) & mask_i & byte_en);

   always_ff @(posedge fe_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         fill_q  <= '0;
         armed_q <= 1'b0;
         match_o <= 1'b0;
      end else begin
         match_o <= hit;                // one shot, armed drops below
         if (!rx_active_i) begin
            fill_q <= '0;               // window empties between packets
         end else if (take) begin
            fill_q <= fill_next;
         end
         if (arm_i) begin
            armed_q <= 1'b1;
         end else if (hit) begin
            armed_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge fe_clk_i) begin
      if (take) begin
         window_q <= window_next;
      end
   end

endmodule

`default_nettype wire

/* common/pw_pkg.sv */
`default_nettype none

package pw_pkg;

   //////////////////////////////////////////////////////////////////////
   // pattern matcher
   //////////////////////////////////////////////////////////////////////

   localparam int PATTERN_BYTES     = 8;                  // bytes in match window
   localparam int PATTERN_WIDTH     = PATTERN_BYTES * 8;  // pattern and mask bits
   localparam int PATTERN_CNT_WIDTH = 4;                  // programmed length, 1..8

   //////////////////////////////////////////////////////////////////////
   // capture records
   //////////////////////////////////////////////////////////////////////

   localparam int TIME_WIDTH        = 8;   // short timestamp, saturates
   localparam int REC_WIDTH         = 18;  // {cmd[17:16], time[15:8], data[7:0]}
   localparam int CAPTURE_LEN_WIDTH = 16;

   localparam int FIFO_DEPTH        = 16;
   localparam int FIFO_ADDR_WIDTH   = 4;

   //////////////////////////////////////////////////////////////////////
   // trigger
   //////////////////////////////////////////////////////////////////////

   localparam int TRIG_DELAY_WIDTH  = 20;
   localparam int TRIG_WIDTH_WIDTH  = 17;

   // record command field
   typedef enum logic [1:0] {
      REC_DATA  = 2'd0,  // data = received byte
      REC_START = 2'd1,  // data = 0
      REC_END   = 2'd2   // data[0] = rxerror seen in packet
   } rec_cmd_e;

endpackage

`default_nettype wire
